/* source/cache_mmu_pkg.sv */
// cache and MMU geometry: address fields, tag widths and the CPU word views
package cache_mmu_pkg;

  // ------------------------------
  // address split
  // ------------------------------
  localparam int line_idx_w = 8;   // addr[7:0] selects the cache line
  localparam int tlb_idx_w  = 8;   // addr[15:8] selects the TLB entry
  localparam int page_tag_w = 16;  // addr[31:16], virtual or physical

  // stored line tag is the physical page tag over the TLB index
  localparam int line_tag_w = page_tag_w + tlb_idx_w;  // 24 bits

  // ------------------------------
  // CPU data word
  // ------------------------------
  // A store sees the word as plain data. A TLB write reads the same bits
  // as an entry: physical tag in the upper half, virtual tag below it.
  typedef union packed {
    logic [31:0] data;
    struct packed {
      logic [page_tag_w-1:0] ptag;  // translated page
      logic [page_tag_w-1:0] vtag;  // page it maps from
    } tlb_entry;
  } cpu_word_u;

endpackage

/* source/mem_bus_pkg.sv */
// memory side constants: Wishbone word width and memory stage FSM encoding
package mem_bus_pkg;

  localparam int word_w = 32;  // wb data and address

  // ------------------------------
  // memory stage FSM
  // ------------------------------
  localparam logic [1:0] ms_idle = 2'd0;  // waiting for mem_go
  localparam logic [1:0] ms_bus  = 2'd1;  // cyc/stb up until ack
  localparam logic [1:0] ms_fill = 2'd2;  // array write and mem_done

endpackage

/* source/sync_ram.sv */
// synchronous RAM with one registered read port and one write port, write-first on collision
`timescale 1ns/1ps

module sync_ram #(
  parameter int width   = 32,
  parameter int depth_w = 8
) (
  input  logic               CPU_CLK,
  input  logic               re,
  input  logic [depth_w-1:0] raddr,
  output logic [width-1:0]   rdata,
  input  logic               we,
  input  logic [depth_w-1:0] waddr,
  input  logic [width-1:0]   wdata
);

  logic [width-1:0] mem [0:(1<<depth_w)-1];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
    if (re)
    begin
      if (we && (waddr == raddr))
        rdata <= wdata;  // same-edge write is seen
      else
        rdata <= mem[raddr];
    end
  end

endmodule

/* source/cache_req_stage.sv */
// request stage: accepts a CPU request, starts the array reads, holds it over stalls
`timescale 1ns/1ps

module cache_req_stage (
  input  logic                                 CPU_CLK,
  input  logic                                 RST,
  input  logic                                 req,
  input  logic [31:0]                          addr,
  input  cache_mmu_pkg::cpu_word_u             wdata,
  input  logic                                 we,
  input  logic                                 tlb_we,
  input  logic                                 vmem_en,
  input  logic                                 cache_inhibit,
  input  logic                                 stall,
  output logic                                 busy,
  output logic                                 ram_re,
  output logic [cache_mmu_pkg::line_idx_w-1:0] line_idx,
  output logic [cache_mmu_pkg::tlb_idx_w-1:0]  tlb_idx,
  output logic                                 s1_vld,
  output logic [31:0]                          s1_addr,
  output cache_mmu_pkg::cpu_word_u             s1_wdata,
  output logic                                 s1_we,
  output logic                                 s1_tlb_we,
  output logic                                 s1_vmem,
  output logic                                 s1_inhibit
);

  logic s1_full;      // a request sits in s1
  logic need_reread;  // held over a stall, array outputs are stale
  logic accept;
  logic reread;

  assign accept = req & ~busy;
  assign reread = need_reread & ~stall;  // stall just released
  assign busy   = stall | need_reread;
  assign s1_vld = s1_full & ~need_reread;

  // ------------------------------
  // array read port
  // ------------------------------
  assign ram_re   = accept | reread;
  assign line_idx = reread ? s1_addr[cache_mmu_pkg::line_idx_w-1:0]
                           : addr[cache_mmu_pkg::line_idx_w-1:0];
  assign tlb_idx  = reread ? s1_addr[cache_mmu_pkg::line_idx_w +: cache_mmu_pkg::tlb_idx_w]
                           : addr[cache_mmu_pkg::line_idx_w +: cache_mmu_pkg::tlb_idx_w];

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      s1_full     <= 1'b0;
      need_reread <= 1'b0;
    end
    else
    begin
      if (accept)
        s1_full <= 1'b1;
      else if (s1_vld && !stall)
        s1_full <= 1'b0;  // taken by lookup

      if (reread)
        need_reread <= 1'b0;
      else if (s1_full && stall)
        need_reread <= 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      s1_addr    <= addr;
      s1_wdata   <= wdata;
      s1_we      <= we;
      s1_tlb_we  <= tlb_we;
      s1_vmem    <= vmem_en;
      s1_inhibit <= cache_inhibit;
    end
  end

endmodule

/* source/cache_lookup_stage.sv */
// lookup stage: address translation, tag compare, MMU fault and hit/miss decision
`timescale 1ns/1ps

module cache_lookup_stage (
  input  logic                                 CPU_CLK,
  input  logic                                 RST,
  input  logic                                 s1_vld,
  input  logic [31:0]                          s1_addr,
  input  cache_mmu_pkg::cpu_word_u             s1_wdata,
  input  logic                                 s1_we,
  input  logic                                 s1_tlb_we,
  input  logic                                 s1_vmem,
  input  logic                                 s1_inhibit,
  input  logic [cache_mmu_pkg::line_tag_w-1:0] tag_rd,
  input  logic [31:0]                          data_rd,
  input  logic [cache_mmu_pkg::page_tag_w-1:0] tlb_ptag_rd,
  input  logic [cache_mmu_pkg::page_tag_w-1:0] tlb_vtag_rd,
  input  logic                                 mem_done,
  input  logic [31:0]                          mem_rdata,
  output cache_mmu_pkg::cpu_word_u             rdata,
  output logic                                 rdata_vld,
  output logic                                 mmu_fault,
  output logic                                 stall,
  output logic                                 tlb_wr,
  output logic [cache_mmu_pkg::tlb_idx_w-1:0]  tlb_waddr,
  output logic [cache_mmu_pkg::page_tag_w-1:0] tlb_wptag,
  output logic [cache_mmu_pkg::page_tag_w-1:0] tlb_wvtag,
  output logic                                 mem_go,
  output logic                                 mem_we,
  output logic                                 mem_fill,
  output logic [31:0]                          mem_paddr,
  output logic [31:0]                          mem_wdata,
  output logic [cache_mmu_pkg::line_tag_w-1:0] mem_line_tag
);

  logic [cache_mmu_pkg::line_idx_w-1:0]      lidx;
  logic [cache_mmu_pkg::tlb_idx_w-1:0]       tidx;
  logic [cache_mmu_pkg::page_tag_w-1:0]      vtag;
  logic [cache_mmu_pkg::page_tag_w-1:0]      ptag;
  logic [(1<<cache_mmu_pkg::line_idx_w)-1:0] line_vld;  // line holds a fill
  logic [(1<<cache_mmu_pkg::tlb_idx_w)-1:0]  tlb_vld;   // entry was written
  logic act;
  logic fault;
  logic hit;
  logic op_tlb;
  logic op_hit;
  logic op_fault;
  logic pend_rd;  // outstanding bus op is a read

  assign lidx = s1_addr[cache_mmu_pkg::line_idx_w-1:0];
  assign tidx = s1_addr[cache_mmu_pkg::line_idx_w +: cache_mmu_pkg::tlb_idx_w];
  assign vtag = s1_addr[31 -: cache_mmu_pkg::page_tag_w];
  assign act  = s1_vld & ~stall;

  // ------------------------------
  // translate and compare
  // ------------------------------
  assign ptag  = s1_vmem ? tlb_ptag_rd : vtag;  // flat when translation is off
  assign fault = s1_vmem & (~tlb_vld[tidx] | (tlb_vtag_rd != vtag));
  assign hit   = line_vld[lidx] & (tag_rd == {ptag, tidx});

  assign op_tlb   = act & s1_tlb_we;
  assign op_fault = act & ~s1_tlb_we & fault;
  assign op_hit   = act & ~s1_tlb_we & ~fault & ~s1_we & ~s1_inhibit & hit;
  assign mem_go   = act & ~s1_tlb_we & ~fault & (s1_we | s1_inhibit | ~hit);

  // TLB entry straight from the CPU word, no bus cycle
  assign tlb_wr    = op_tlb;
  assign tlb_waddr = tidx;
  assign tlb_wptag = s1_wdata.tlb_entry.ptag;
  assign tlb_wvtag = s1_wdata.tlb_entry.vtag;

  assign mem_we       = s1_we;
  assign mem_fill     = ~s1_inhibit;  // inhibited ops leave the line alone
  assign mem_paddr    = {ptag, s1_addr[31-cache_mmu_pkg::page_tag_w:0]};
  assign mem_wdata    = s1_wdata.data;
  assign mem_line_tag = {ptag, tidx};

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      stall     <= 1'b0;
      rdata_vld <= 1'b0;
      mmu_fault <= 1'b0;
      pend_rd   <= 1'b0;
      line_vld  <= '0;
      tlb_vld   <= '0;
    end
    else
    begin
      rdata_vld <= op_hit | (mem_done & pend_rd);
      mmu_fault <= op_fault;
      if (mem_go)
      begin
        stall   <= 1'b1;
        pend_rd <= ~s1_we;
      end
      else if (mem_done)
        stall <= 1'b0;
      if (mem_go && mem_fill)
        line_vld[lidx] <= 1'b1;  // written before stall drops
      if (op_tlb)
        tlb_vld[tidx] <= 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (op_hit)
      rdata.data <= data_rd;
    else if (mem_done)
      rdata.data <= mem_rdata;
  end

endmodule

/* source/cache_mem_stage.sv */
// memory stage: Wishbone classic master with line refill and store write-back
`timescale 1ns/1ps

module cache_mem_stage (
  input  logic                                 CPU_CLK,
  input  logic                                 RST,
  input  logic                                 mem_go,
  input  logic                                 mem_we,
  input  logic                                 mem_fill,
  input  logic [mem_bus_pkg::word_w-1:0]       mem_paddr,
  input  logic [mem_bus_pkg::word_w-1:0]       mem_wdata,
  input  logic [cache_mmu_pkg::line_tag_w-1:0] mem_line_tag,
  input  logic [mem_bus_pkg::word_w-1:0]       wb_rdata,
  input  logic                                 wb_ack,
  output logic                                 wb_cyc,
  output logic                                 wb_stb,
  output logic                                 wb_we,
  output logic [mem_bus_pkg::word_w-1:0]       wb_adr,
  output logic [mem_bus_pkg::word_w-1:0]       wb_wdata,
  output logic                                 data_wr,
  output logic [cache_mmu_pkg::line_idx_w-1:0] data_waddr,
  output logic [mem_bus_pkg::word_w-1:0]       data_wdata,
  output logic [cache_mmu_pkg::line_tag_w-1:0] tag_wdata,
  output logic                                 mem_done,
  output logic [mem_bus_pkg::word_w-1:0]       mem_rdata
);

  logic [1:0]                           state;
  logic                                 start;
  logic                                 fill_q;      // update arrays at the end
  logic [cache_mmu_pkg::line_tag_w-1:0] line_tag_q;

  assign start = mem_go & (state == mem_bus_pkg::ms_idle);

  // ------------------------------
  // array write port
  // ------------------------------
  assign mem_done   = (state == mem_bus_pkg::ms_fill);
  assign data_wr    = mem_done & fill_q;
  assign data_waddr = wb_adr[cache_mmu_pkg::line_idx_w-1:0];
  assign data_wdata = wb_we ? wb_wdata : mem_rdata;  // stored or fetched word
  assign tag_wdata  = line_tag_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state  <= mem_bus_pkg::ms_idle;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end
    else
    begin
      case (state)
        mem_bus_pkg::ms_idle:
        begin
          if (start)
          begin
            wb_cyc <= 1'b1;  // cyc and stb rise together
            wb_stb <= 1'b1;
            state  <= mem_bus_pkg::ms_bus;
          end
        end
        mem_bus_pkg::ms_bus:
        begin
          if (wb_ack)
          begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state  <= mem_bus_pkg::ms_fill;
          end
        end
        default:
          state <= mem_bus_pkg::ms_idle;  // fill lasts one cycle
      endcase
    end
  end

  // bus outputs hold from start until the ack edge
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      wb_we      <= mem_we;
      wb_adr     <= mem_paddr;
      wb_wdata   <= mem_wdata;
      fill_q     <= mem_fill;
      line_tag_q <= mem_line_tag;
    end
    if ((state == mem_bus_pkg::ms_bus) && wb_ack && !wb_we)
      mem_rdata <= wb_rdata;
  end

endmodule

/* source/snowball_cache_top.sv */
// cache top level: request, lookup and memory stages around the data, tag and TLB arrays
`timescale 1ns/1ps

module snowball_cache_top (
  input  logic                           CPU_CLK,
  input  logic                           RST,
  // CPU port
  input  logic                           req,
  input  logic [31:0]                    addr,
  input  cache_mmu_pkg::cpu_word_u       wdata,
  input  logic                           we,
  input  logic                           tlb_we,
  input  logic                           vmem_en,
  input  logic                           cache_inhibit,
  output cache_mmu_pkg::cpu_word_u       rdata,
  output logic                           rdata_vld,
  output logic                           busy,
  output logic                           mmu_fault,
  // Wishbone master
  output logic                           wb_cyc,
  output logic                           wb_stb,
  output logic                           wb_we,
  output logic [mem_bus_pkg::word_w-1:0] wb_adr,
  output logic [mem_bus_pkg::word_w-1:0] wb_wdata,
  input  logic [mem_bus_pkg::word_w-1:0] wb_rdata,
  input  logic                           wb_ack
);

  // ------------------------------
  // stage links
  // ------------------------------
  logic                                 stall;
  logic                                 ram_re;
  logic [cache_mmu_pkg::line_idx_w-1:0] line_idx;
  logic [cache_mmu_pkg::tlb_idx_w-1:0]  tlb_idx;
  logic                                 s1_vld;
  logic [31:0]                          s1_addr;
  cache_mmu_pkg::cpu_word_u             s1_wdata;
  logic                                 s1_we;
  logic                                 s1_tlb_we;
  logic                                 s1_vmem;
  logic                                 s1_inhibit;
  logic [cache_mmu_pkg::line_tag_w-1:0] tag_rd;
  logic [31:0]                          data_rd;
  logic [cache_mmu_pkg::page_tag_w-1:0] tlb_ptag_rd;
  logic [cache_mmu_pkg::page_tag_w-1:0] tlb_vtag_rd;
  logic                                 tlb_wr;
  logic [cache_mmu_pkg::tlb_idx_w-1:0]  tlb_waddr;
  logic [cache_mmu_pkg::page_tag_w-1:0] tlb_wptag;
  logic [cache_mmu_pkg::page_tag_w-1:0] tlb_wvtag;
  logic                                 mem_go;
  logic                                 mem_we;
  logic                                 mem_fill;
  logic [31:0]                          mem_paddr;
  logic [31:0]                          mem_wdata;
  logic [cache_mmu_pkg::line_tag_w-1:0] mem_line_tag;
  logic                                 mem_done;
  logic [31:0]                          mem_rdata;
  logic                                 data_wr;
  logic [cache_mmu_pkg::line_idx_w-1:0] data_waddr;
  logic [31:0]                          data_wdata;
  logic [cache_mmu_pkg::line_tag_w-1:0] tag_wdata;

  cache_req_stage i_req (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .req(req), .addr(addr), .wdata(wdata), .we(we), .tlb_we(tlb_we),
    .vmem_en(vmem_en), .cache_inhibit(cache_inhibit), .stall(stall),
    .busy(busy), .ram_re(ram_re), .line_idx(line_idx), .tlb_idx(tlb_idx),
    .s1_vld(s1_vld), .s1_addr(s1_addr), .s1_wdata(s1_wdata), .s1_we(s1_we),
    .s1_tlb_we(s1_tlb_we), .s1_vmem(s1_vmem), .s1_inhibit(s1_inhibit)
  );

  cache_lookup_stage i_lookup (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .s1_vld(s1_vld), .s1_addr(s1_addr), .s1_wdata(s1_wdata), .s1_we(s1_we),
    .s1_tlb_we(s1_tlb_we), .s1_vmem(s1_vmem), .s1_inhibit(s1_inhibit),
    .tag_rd(tag_rd), .data_rd(data_rd),
    .tlb_ptag_rd(tlb_ptag_rd), .tlb_vtag_rd(tlb_vtag_rd),
    .mem_done(mem_done), .mem_rdata(mem_rdata),
    .rdata(rdata), .rdata_vld(rdata_vld), .mmu_fault(mmu_fault), .stall(stall),
    .tlb_wr(tlb_wr), .tlb_waddr(tlb_waddr), .tlb_wptag(tlb_wptag), .tlb_wvtag(tlb_wvtag),
    .mem_go(mem_go), .mem_we(mem_we), .mem_fill(mem_fill), .mem_paddr(mem_paddr),
    .mem_wdata(mem_wdata), .mem_line_tag(mem_line_tag)
  );

  cache_mem_stage i_mem (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .mem_go(mem_go), .mem_we(mem_we), .mem_fill(mem_fill), .mem_paddr(mem_paddr),
    .mem_wdata(mem_wdata), .mem_line_tag(mem_line_tag),
    .wb_rdata(wb_rdata), .wb_ack(wb_ack),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_wdata(wb_wdata),
    .data_wr(data_wr), .data_waddr(data_waddr), .data_wdata(data_wdata),
    .tag_wdata(tag_wdata), .mem_done(mem_done), .mem_rdata(mem_rdata)
  );

  // ------------------------------
  // arrays, all read at the accept edge
  // ------------------------------
  sync_ram #(.width(32), .depth_w(cache_mmu_pkg::line_idx_w)) cache_data (
    .CPU_CLK(CPU_CLK), .re(ram_re), .raddr(line_idx), .rdata(data_rd),
    .we(data_wr), .waddr(data_waddr), .wdata(data_wdata)
  );

  sync_ram #(.width(cache_mmu_pkg::line_tag_w), .depth_w(cache_mmu_pkg::line_idx_w)) cache_tag (
    .CPU_CLK(CPU_CLK), .re(ram_re), .raddr(line_idx), .rdata(tag_rd),
    .we(data_wr), .waddr(data_waddr), .wdata(tag_wdata)
  );

  sync_ram #(.width(cache_mmu_pkg::page_tag_w), .depth_w(cache_mmu_pkg::tlb_idx_w)) tlb_ptag (
    .CPU_CLK(CPU_CLK), .re(ram_re), .raddr(tlb_idx), .rdata(tlb_ptag_rd),
    .we(tlb_wr), .waddr(tlb_waddr), .wdata(tlb_wptag)
  );

  sync_ram #(.width(cache_mmu_pkg::page_tag_w), .depth_w(cache_mmu_pkg::tlb_idx_w)) tlb_vtag (
    .CPU_CLK(CPU_CLK), .re(ram_re), .raddr(tlb_idx), .rdata(tlb_vtag_rd),
    .we(tlb_wr), .waddr(tlb_waddr), .wdata(tlb_wvtag)
  );

endmodule

/* tb/snowball_cache_checker.sv */
// protocol checker: Wishbone master and CPU port rules of the cache top level
`timescale 1ns/1ps

module snowball_cache_checker (
  input logic                           CPU_CLK,
  input logic                           RST,
  input logic                           busy,
  input logic                           rdata_vld,
  input logic                           mmu_fault,
  input logic                           wb_cyc,
  input logic                           wb_stb,
  input logic                           wb_we,
  input logic [mem_bus_pkg::word_w-1:0] wb_adr,
  input logic [mem_bus_pkg::word_w-1:0] wb_wdata,
  input logic                           wb_ack
);

  int fail_count = 0;  // failed assertions so far

  stb_needs_cyc: assert property (@(posedge CPU_CLK) disable iff (!RST) wb_stb |-> wb_cyc)
    else
    begin
      fail_count++;
      $error("wb_stb high without wb_cyc");
    end

  // ------------------------------
  // bus hold until ack
  // ------------------------------
  bus_held: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (wb_stb && !wb_ack) |=> $stable({wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata}))
    else
    begin
      fail_count++;
      $error("bus outputs changed before ack");
    end

  one_result: assert property (@(posedge CPU_CLK) disable iff (!RST) !(rdata_vld && mmu_fault))
    else
    begin
      fail_count++;
      $error("rdata_vld and mmu_fault high together");
    end

  quiet_after_reset: assert property (@(posedge CPU_CLK)
    !RST |=> (!busy && !rdata_vld && !mmu_fault && !wb_cyc && !wb_stb))
    else
    begin
      fail_count++;
      $error("outputs not idle after reset");
    end

endmodule

bind snowball_cache_top snowball_cache_checker i_checker (.*);

/* tb/snowball_cache_tb.sv */
// cache testbench: trace-driven CPU requests against a Wishbone slave memory model
`timescale 1ns/1ps

module snowball_cache_tb;

  localparam int clk_period = 40;
  localparam int max_ops    = 64;

  logic                           CPU_CLK;
  logic                           RST;
  logic                           req;
  logic [31:0]                    addr;
  cache_mmu_pkg::cpu_word_u       wdata;
  logic                           we;
  logic                           tlb_we;
  logic                           vmem_en;
  logic                           cache_inhibit;
  cache_mmu_pkg::cpu_word_u       rdata;
  logic                           rdata_vld;
  logic                           busy;
  logic                           mmu_fault;
  logic                           wb_cyc;
  logic                           wb_stb;
  logic                           wb_we;
  logic [mem_bus_pkg::word_w-1:0] wb_adr;
  logic [mem_bus_pkg::word_w-1:0] wb_wdata;
  logic [mem_bus_pkg::word_w-1:0] wb_rdata;
  logic                           wb_ack;

  logic [147:0] trace [0:max_ops-1];  // one operation per entry
  logic [31:0]  mem_data [0:63];
  logic [31:0]  mem_tag [0:63];       // full address held in each slot
  logic [1:0]   kind_q [$];           // 1 data, 2 fault
  logic [31:0]  val_q [$];
  int           acc_q [$];            // accept cycle, -1 if latency varies
  logic [64:0]  bus_q [$];            // we, wdata, address
  int           n_ops;
  int           cycle  = 0;
  integer       seed   = 32'h9081_8734;

  snowball_cache_top i_dut (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever
      #(clk_period/2) CPU_CLK = ~CPU_CLK;
  end

  always @(posedge CPU_CLK)
    cycle <= cycle + 1;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_rdata(input cache_mmu_pkg::cpu_word_u got,
                             input cache_mmu_pkg::cpu_word_u exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: rdata got %h expected %h", $time, got.data, exp.data);
      stop_run();
    end
  endtask

  task automatic check_fault(input bit got, input bit exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: mmu_fault got %0d expected %0d", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bus_addr(input logic [mem_bus_pkg::word_w-1:0] got,
                                input logic [mem_bus_pkg::word_w-1:0] exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: wb_adr got %h expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bus_wdata(input logic [mem_bus_pkg::word_w-1:0] got,
                                 input logic [mem_bus_pkg::word_w-1:0] exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t ns: wb_wdata got %h expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  initial
  begin : assertion_watch
    wait (i_dut.i_checker.fail_count != 0);
    $display("a bus or CPU port assertion failed at %0t ns", $time);
    stop_run();
  end

  // ------------------------------
  // CPU side
  // ------------------------------
  task automatic issue_op(input logic [147:0] t);
    logic [3:0] op;
    logic       timed;
    op            = t[147:144];
    req           = 1'b1;
    we            = (op == 4'd1);
    tlb_we        = (op == 4'd2);
    vmem_en       = t[140];
    cache_inhibit = t[136];
    addr          = t[135:104];
    wdata.data    = t[103:72];
    @(negedge CPU_CLK);
    while (busy)
      @(negedge CPU_CLK);  // taken at the next rising edge
    timed = !t[32] && (bus_q.size() == 0);  // nothing ahead on the bus
    if (t[71:68] != 4'd0)
    begin
      kind_q.push_back(t[69:68]);
      val_q.push_back(t[67:36]);
      acc_q.push_back(timed ? cycle : -1);
    end
    if (t[32])
      bus_q.push_back({we, t[103:72], t[31:0]});
    @(posedge CPU_CLK);
    #2;
    req = 1'b0;
  endtask

  initial
  begin : result_monitor
    cache_mmu_pkg::cpu_word_u exp_word;
    logic [1:0]               kind;
    int                       acc;
    forever
    begin
      @(negedge CPU_CLK);
      if (RST && (rdata_vld || mmu_fault))
      begin
        if (kind_q.size() == 0)
        begin
          $display("result pulse at %0t ns while no read was pending", $time);
          stop_run();
        end
        kind          = kind_q.pop_front();
        exp_word.data = val_q.pop_front();
        acc           = acc_q.pop_front();
        check_fault(mmu_fault, kind == 2'd2);
        if (kind == 2'd1)
          check_rdata(rdata, exp_word);
        if ((acc >= 0) && (cycle - acc != 2))
        begin
          $display("result at %0t ns came %0d cycles after accept, not 2", $time, cycle - acc);
          stop_run();
        end
      end
    end
  end

  // ------------------------------
  // Wishbone slave
  // ------------------------------
  initial
  begin : wb_slave
    int          waits;
    logic [64:0] exp_bus;
    logic [5:0]  slot;
    wb_ack   = 1'b0;
    wb_rdata = '0;
    forever
    begin
      @(negedge CPU_CLK);
      if (wb_cyc && wb_stb)
      begin
        waits = $unsigned($random(seed)) % 6;
        repeat (waits)
          @(posedge CPU_CLK);
        @(posedge CPU_CLK);
        #2;
        if (bus_q.size() == 0)
        begin
          $display("bus cycle at %0t ns that no operation should make", $time);
          stop_run();
        end
        exp_bus = bus_q.pop_front();
        if (wb_we !== exp_bus[64])
        begin
          $display("bus cycle at %0t ns goes the wrong direction", $time);
          stop_run();
        end
        check_bus_addr(wb_adr, exp_bus[31:0]);
        slot = wb_adr[5:0];
        if (wb_we)
        begin
          check_bus_wdata(wb_wdata, exp_bus[63:32]);
          mem_data[slot] = wb_wdata;
          mem_tag[slot]  = wb_adr;
        end
        else if (mem_tag[slot] === wb_adr)
          wb_rdata = mem_data[slot];
        else
          wb_rdata = {wb_adr[15:0], wb_adr[31:16]};  // untouched word, halves swapped
        wb_ack = 1'b1;
        @(posedge CPU_CLK);
        #2;
        wb_ack = 1'b0;
      end
    end
  end

  initial
  begin : main
    int i;
    RST           = 1'b0;
    req           = 1'b0;
    addr          = '0;
    wdata         = '0;
    we            = 1'b0;
    tlb_we        = 1'b0;
    vmem_en       = 1'b0;
    cache_inhibit = 1'b0;
    $readmemh("tb/cache_trace.txt", trace);
    n_ops = 0;
    while ((n_ops < max_ops) && (trace[n_ops][147:144] !== 4'hf))
      n_ops++;
    if ((n_ops == 0) || (n_ops == max_ops))
    begin
      $display("trace file is missing or has no end marker");
      stop_run();
    end
    fork
      begin
        #(n_ops * 20 * clk_period);
        $display("watchdog expired, %0d operations did not finish in time", n_ops);
        stop_run();
      end
    join_none
    repeat (10)
      @(posedge CPU_CLK);
    #2;
    RST = 1'b1;
    for (i = 0; i < n_ops; i++)
      issue_op(trace[i]);
    while (busy || (kind_q.size() != 0) || (bus_q.size() != 0))
      @(negedge CPU_CLK);
    repeat (4)
      @(negedge CPU_CLK);  // room for a stray pulse
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* tb/cache_trace.txt */
// op_vm_inh_addr_data_kind_value_bus_busadr, op 0 read 1 write 2 tlb f end of trace
// kind 0 none 1 data 2 fault; bus 1 when one bus cycle at busadr is expected
0_0_0_00001234_00000000_1_12340000_1_00001234
0_0_0_00001234_00000000_1_12340000_0_00000000
1_0_0_00001240_cafe0001_0_00000000_1_00001240
0_0_0_00001240_00000000_1_cafe0001_0_00000000
2_0_0_00052200_00770005_0_00000000_0_00000000
0_1_0_00052210_00000000_1_22100077_1_00772210
0_1_0_00052210_00000000_1_22100077_0_00000000
0_1_0_00092214_00000000_2_00000000_0_00000000
0_1_0_00013300_00000000_2_00000000_0_00000000
1_1_0_00052218_11112222_0_00000000_1_00772218
0_1_0_00052218_00000000_1_11112222_0_00000000
0_0_1_00001234_00000000_1_12340000_1_00001234
1_0_1_00001234_beef0002_0_00000000_1_00001234
0_0_0_00001234_00000000_1_12340000_0_00000000
0_0_1_00001234_00000000_1_beef0002_1_00001234
0_0_0_00010034_00000000_1_00340001_1_00010034
0_0_0_00001234_00000000_1_beef0002_1_00001234
0_0_0_00010034_00000000_1_00340001_1_00010034
0_0_0_00001240_00000000_1_cafe0001_0_00000000
0_1_0_00052210_00000000_1_22100077_0_00000000
0_0_0_00001240_00000000_1_cafe0001_0_00000000
f_0_0_00000000_00000000_0_00000000_0_00000000

/* snowball_cache_top.f */
source/cache_mmu_pkg.sv
source/mem_bus_pkg.sv
source/sync_ram.sv
source/cache_req_stage.sv
source/cache_lookup_stage.sv
source/cache_mem_stage.sv
source/snowball_cache_top.sv
tb/snowball_cache_checker.sv
tb/snowball_cache_tb.sv
